// ==== common/exec_pkg.sv ====
// Execute stage shared definitions
// Micro-op encoding, sequence tag width and the dispatch-to-execute
// and execute-to-writeback message formats

`default_nettype none

package exec_pkg;

  //--------------------------------------------------------------------
  // Sequence tag
  //--------------------------------------------------------------------

  // Reorder tag carried from dispatch through to writeback
  localparam int SEQ_NUM_BITS = 5;

  //--------------------------------------------------------------------
  // ALU micro-ops
  //--------------------------------------------------------------------

  typedef enum logic [3:0] {
    UOP_ADD  = 4'd0,
    UOP_SUB  = 4'd1,
    UOP_AND  = 4'd2,
    UOP_OR   = 4'd3,
    UOP_XOR  = 4'd4,
    // Shifts take op2[4:0] as the amount
    UOP_SLL  = 4'd5,
    UOP_SRL  = 4'd6,
    UOP_SRA  = 4'd7,
    // Compares give 1 or 0
    UOP_SLT  = 4'd8,
    UOP_SLTU = 4'd9,
    // Upper immediate already formed in op2
    UOP_LUI  = 4'd10
  } rv_uop;

  //--------------------------------------------------------------------
  // Dispatch to execute, 110 bits
  //--------------------------------------------------------------------

  typedef struct packed {
    logic [31:0]             pc;
    logic [SEQ_NUM_BITS-1:0] seq_num;
    logic [31:0]             op1;
    logic [31:0]             op2;
    // Architectural destination
    logic [4:0]              waddr;
    rv_uop                   uop;
  } d_x_msg_t;

  //--------------------------------------------------------------------
  // Execute to writeback, 75 bits
  //--------------------------------------------------------------------

  typedef struct packed {
    logic [31:0]             pc;
    logic [SEQ_NUM_BITS-1:0] seq_num;
    logic [4:0]              waddr;
    logic [31:0]             wdata;
    // Low for x0 destinations
    logic                    wen;
  } x_w_msg_t;

endpackage

`default_nettype wire

// ==== flist.f ====
common/exec_pkg.sv
hw/alu/alu_core.sv
hw/alu/alu_l1.sv
hw/exec_dispatch.sv
hw/wb_arbiter.sv
hw/exec_alu_top.sv
verif/exec_alu_chk.sv
verif/exec_alu_tb.sv

// ==== hw/alu/alu_core.sv ====
// ALU datapath
// Purely combinational: one 32-bit result per micro-op, covering add,
// logic, shift, compare and upper-immediate pass-through

`timescale 1ns/1ps
`default_nettype none

module alu_core (
  input  exec_pkg::rv_uop uop,
  input  logic [31:0]     op1,
  input  logic [31:0]     op2,
  output logic [31:0]     result
);

  //--------------------------------------------------------------------
  // Operand preparation
  //--------------------------------------------------------------------

  // Only the low 5 bits select the shift distance
  logic [4:0]  shamt;
  logic        lt_signed;
  logic        lt_unsigned;
  logic [31:0] sum;
  logic [31:0] diff;

  assign shamt = op2[4:0];

  // Wrapping arithmetic, overflow simply drops the carry
  assign sum  = op1 + op2;
  assign diff = op1 - op2;

  // Compare flavours
  assign lt_signed   = $signed(op1) < $signed(op2);
  assign lt_unsigned = op1 < op2;

  //--------------------------------------------------------------------
  // Result select
  //--------------------------------------------------------------------

  always_comb begin
    case (uop)
      exec_pkg::UOP_ADD: begin
        result = sum;
      end
      exec_pkg::UOP_SUB: begin
        result = diff;
      end
      exec_pkg::UOP_AND: begin
        result = op1 & op2;
      end
      exec_pkg::UOP_OR: begin
        result = op1 | op2;
      end
      exec_pkg::UOP_XOR: begin
        result = op1 ^ op2;
      end
      exec_pkg::UOP_SLL: begin
        result = op1 << shamt;
      end
      exec_pkg::UOP_SRL: begin
        result = op1 >> shamt;
      end
      exec_pkg::UOP_SRA: begin
        // Sign bit fills from the left
        result = $unsigned($signed(op1) >>> shamt);
      end
      exec_pkg::UOP_SLT: begin
        result = {31'd0, lt_signed};
      end
      exec_pkg::UOP_SLTU: begin
        result = {31'd0, lt_unsigned};
      end
      exec_pkg::UOP_LUI: begin
        result = op2;
      end
      default: begin
        // Unused encodings
        result = 32'd0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/alu/alu_l1.sv ====
// Single ALU lane
// One register stage behind alu_core, valid/ready on both sides,
// accepts a new op each cycle while the output drains

`timescale 1ns/1ps
`default_nettype none

module alu_l1 (
  input  logic               clk,
  input  logic               rst,

  // Dispatch side
  input  exec_pkg::d_x_msg_t d_msg,
  input  logic               d_val,
  output logic               d_rdy,

  // Writeback side
  output exec_pkg::x_w_msg_t w_msg,
  output logic               w_val,
  input  logic               w_rdy
);

  //--------------------------------------------------------------------
  // Datapath
  //--------------------------------------------------------------------

  logic [31:0]        core_result;
  exec_pkg::x_w_msg_t next_msg;
  exec_pkg::x_w_msg_t msg_q;
  logic               val_q;
  logic               load;

  alu_core u_core (
    .uop    (d_msg.uop),
    .op1    (d_msg.op1),
    .op2    (d_msg.op2),
    .result (core_result)
  );

  // Pack the outgoing message before the register
  always_comb begin
    next_msg.pc      = d_msg.pc;
    next_msg.seq_num = d_msg.seq_num;
    next_msg.waddr   = d_msg.waddr;
    next_msg.wdata   = core_result;
    // x0 never gets written
    next_msg.wen     = (d_msg.waddr != 5'd0);
  end

  //--------------------------------------------------------------------
  // Flow control
  //--------------------------------------------------------------------

  // Room when empty or when the held result leaves this cycle
  assign d_rdy = !val_q || w_rdy;
  assign load  = d_val && d_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      val_q <= 1'b0;
    end else if (load) begin
      val_q <= 1'b1;
    end else if (w_rdy) begin
      // Drained with nothing behind it
      val_q <= 1'b0;
    end
  end

  // Payload only moves on accept, otherwise held through a stall
  always_ff @(posedge clk) begin
    if (load) begin
      msg_q <= next_msg;
    end
  end

  assign w_msg = msg_q;
  assign w_val = val_q;

endmodule

`default_nettype wire

// ==== hw/exec_alu_top.sv ====
// Integer ALU execute block
// Dispatch fan-out to parallel single-cycle ALU lanes, merged back
// onto one writeback port; results may leave out of order

`timescale 1ns/1ps
`default_nettype none

module exec_alu_top #(
  parameter int num_lanes = 2
) (
  input  logic               clk,
  input  logic               rst,

  // D port
  input  exec_pkg::d_x_msg_t d_msg,
  input  logic               d_val,
  output logic               d_rdy,

  // W port
  output exec_pkg::x_w_msg_t w_msg,
  output logic               w_val,
  input  logic               w_rdy
);

  //--------------------------------------------------------------------
  // Lane links
  //--------------------------------------------------------------------

  exec_pkg::d_x_msg_t   lane_d_msg [num_lanes];
  logic [num_lanes-1:0] lane_d_val;
  logic [num_lanes-1:0] lane_d_rdy;

  exec_pkg::x_w_msg_t   lane_w_msg [num_lanes];
  logic [num_lanes-1:0] lane_w_val;
  logic [num_lanes-1:0] lane_w_rdy;

  // Round-robin steering into the lanes
  exec_dispatch #(
    .num_lanes (num_lanes)
  ) u_dispatch (
    .clk        (clk),
    .rst        (rst),
    .d_msg      (d_msg),
    .d_val      (d_val),
    .d_rdy      (d_rdy),
    .lane_d_msg (lane_d_msg),
    .lane_d_val (lane_d_val),
    .lane_d_rdy (lane_d_rdy)
  );

  // One registered ALU per lane
  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    alu_l1 u_alu (
      .clk   (clk),
      .rst   (rst),
      .d_msg (lane_d_msg[i]),
      .d_val (lane_d_val[i]),
      .d_rdy (lane_d_rdy[i]),
      .w_msg (lane_w_msg[i]),
      .w_val (lane_w_val[i]),
      .w_rdy (lane_w_rdy[i])
    );
  end

  // Merge onto writeback
  wb_arbiter #(
    .num_lanes (num_lanes)
  ) u_wb_arb (
    .clk        (clk),
    .rst        (rst),
    .lane_w_msg (lane_w_msg),
    .lane_w_val (lane_w_val),
    .lane_w_rdy (lane_w_rdy),
    .w_msg      (w_msg),
    .w_val      (w_val),
    .w_rdy      (w_rdy)
  );

endmodule

`default_nettype wire

// ==== hw/exec_dispatch.sv ====
// Lane distributor
// Rotates dispatched ops across the ALU lanes one at a time; the
// pointer waits on a busy lane rather than skipping it

`timescale 1ns/1ps
`default_nettype none

module exec_dispatch #(
  parameter int num_lanes = 2
) (
  input  logic               clk,
  input  logic               rst,

  // Upstream dispatch port
  input  exec_pkg::d_x_msg_t d_msg,
  input  logic               d_val,
  output logic               d_rdy,

  // Per-lane ports
  output exec_pkg::d_x_msg_t lane_d_msg [num_lanes],
  output logic [num_lanes-1:0] lane_d_val,
  input  logic [num_lanes-1:0] lane_d_rdy
);

  localparam int ptr_bits = $clog2(num_lanes);

  // Next lane to receive an op
  logic [ptr_bits-1:0] ptr_q;

  //--------------------------------------------------------------------
  // Steering
  //--------------------------------------------------------------------

  // Payload fans out to every lane, only val is steered
  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    assign lane_d_msg[i] = d_msg;
    assign lane_d_val[i] = d_val && (ptr_q == ptr_bits'(i));
  end

  assign d_rdy = lane_d_rdy[ptr_q];

  //--------------------------------------------------------------------
  // Rotation
  //--------------------------------------------------------------------

  // Power-of-two lane count, so the wrap is free
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q <= '0;
    end else if (d_val && d_rdy) begin
      ptr_q <= ptr_q + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/wb_arbiter.sv ====
// Writeback merge
// Round-robin pick among lane results onto one W port; a stalled
// grant is held so the presented message cannot change under it

`timescale 1ns/1ps
`default_nettype none

module wb_arbiter #(
  parameter int num_lanes = 2
) (
  input  logic               clk,
  input  logic               rst,

  // Lane results
  input  exec_pkg::x_w_msg_t lane_w_msg [num_lanes],
  input  logic [num_lanes-1:0] lane_w_val,
  output logic [num_lanes-1:0] lane_w_rdy,

  // Merged writeback port
  output exec_pkg::x_w_msg_t w_msg,
  output logic               w_val,
  input  logic               w_rdy
);

  localparam int ptr_bits = $clog2(num_lanes);

  logic [ptr_bits-1:0] ptr_q;
  logic                hold_q;
  logic [ptr_bits-1:0] hold_idx_q;

  logic [ptr_bits-1:0] scan_idx;
  logic [ptr_bits-1:0] pick_idx;
  logic                pick_found;
  logic [ptr_bits-1:0] grant;

  //--------------------------------------------------------------------
  // Fresh pick
  //--------------------------------------------------------------------

  // Walk from the far end so the nearest valid lane wins
  always_comb begin
    pick_found = 1'b0;
    pick_idx   = ptr_q;
    scan_idx   = ptr_q;
    for (int k = num_lanes - 1; k >= 0; k--) begin
      scan_idx = ptr_q + ptr_bits'(k);
      if (lane_w_val[scan_idx]) begin
        pick_found = 1'b1;
        pick_idx   = scan_idx;
      end
    end
  end

  //--------------------------------------------------------------------
  // Output mux
  //--------------------------------------------------------------------

  // Held lane wins over any new pick
  assign grant = hold_q ? hold_idx_q : pick_idx;
  assign w_val = hold_q ? lane_w_val[hold_idx_q] : pick_found;
  assign w_msg = lane_w_msg[grant];

  for (genvar i = 0; i < num_lanes; i++) begin : g_rdy
    assign lane_w_rdy[i] = w_val && w_rdy && (grant == ptr_bits'(i));
  end

  //--------------------------------------------------------------------
  // Pointer and hold state
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q  <= '0;
      hold_q <= 1'b0;
    end else if (w_val && w_rdy) begin
      // Served lane goes to the back of the line
      ptr_q  <= grant + 1'b1;
      hold_q <= 1'b0;
    end else if (w_val) begin
      hold_q <= 1'b1;
    end
  end

  // Index only matters while hold_q is set
  always_ff @(posedge clk) begin
    if (w_val && !w_rdy) begin
      hold_idx_q <= grant;
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the exec ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  --top-module exec_alu_tb \
  -f flist.f \
  -o exec_alu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/exec_alu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  exit 0
else
  exit 1
fi

// ==== verif/exec_alu_chk.sv ====
// Handshake checker for the execute block ports
// Bound into exec_alu_top, flags stalled-output and reset violations

`timescale 1ns/1ps
`default_nettype none

module exec_alu_chk (
  input logic               clk,
  input logic               rst,
  input logic               d_rdy,
  input exec_pkg::x_w_msg_t w_msg,
  input logic               w_val,
  input logic               w_rdy
);

  //--------------------------------------------------------------------
  // W port
  //--------------------------------------------------------------------

  // Stalled result stays offered and unchanged
  w_hold_a: assert property (@(posedge clk) disable iff (rst)
    (w_val && !w_rdy) |=> (w_val && $stable(w_msg)))
    else $error("w_val dropped or w_msg changed during a stall");

  // Lane registers cleared after the first reset edge
  w_rst_a: assert property (@(posedge clk)
    (rst && $past(rst)) |-> !w_val)
    else $error("w_val high while rst held");

  //--------------------------------------------------------------------
  // D port
  //--------------------------------------------------------------------

  d_known_a: assert property (@(posedge clk) disable iff (rst)
    !$isunknown(d_rdy))
    else $error("d_rdy unknown out of reset");

endmodule

bind exec_alu_top exec_alu_chk u_chk (
  .clk   (clk),
  .rst   (rst),
  .d_rdy (d_rdy),
  .w_msg (w_msg),
  .w_val (w_val),
  .w_rdy (w_rdy)
);

`default_nettype wire

// ==== verif/exec_alu_tb.sv ====
// Execute block testbench
// Table-driven ALU ops through the lanes, seq_num scoreboard on W,
// a free-flowing phase and a random back-pressure phase

`timescale 1ns/1ps
`default_nettype none

module exec_alu_tb;

  typedef struct packed {
    exec_pkg::d_x_msg_t msg;
    logic [31:0]        wdata;
    logic               wen;
  } vec_t;

  localparam int tag_count     = 1 << exec_pkg::SEQ_NUM_BITS;
  localparam int rdy_timeout   = 50;
  localparam int drain_timeout = 500;
  localparam int tail_cycles   = 20;

  logic               clk;
  logic               rst;
  exec_pkg::d_x_msg_t d_msg;
  logic               d_val;
  logic               d_rdy;
  exec_pkg::x_w_msg_t w_msg;
  logic               w_val;
  logic               w_rdy = 1'b1;
  logic               bp_mode;

  vec_t                                vectors [$];
  logic [exec_pkg::SEQ_NUM_BITS-1:0]   seq_ctr;
  exec_pkg::x_w_msg_t                  expected [tag_count];
  logic                                pending [tag_count];
  int pending_count = 0;
  int sent_count    = 0;
  int seen_count    = 0;
  int check_errors  = 0;
  int tag_errors    = 0;
  int timeout_errors = 0;
  int missing_errors = 0;

  exec_alu_top #(.num_lanes(2)) dut0 (
    .clk(clk), .rst(rst),
    .d_msg(d_msg), .d_val(d_val), .d_rdy(d_rdy),
    .w_msg(w_msg), .w_val(w_val), .w_rdy(w_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Downstream ready is random only in the back-pressure phase
  always @(posedge clk) begin
    if (bp_mode) begin
      w_rdy <= ($urandom % 3) != 0;
    end else begin
      w_rdy <= 1'b1;
    end
  end

  //--------------------------------------------------------------------
  // Stimulus table
  //--------------------------------------------------------------------

  task automatic add_vec(input exec_pkg::rv_uop uop, input logic [31:0] op1,
                         input logic [31:0] op2, input logic [4:0] waddr,
                         input logic [31:0] wdata, input logic wen);
    vec_t v;
    v.msg.pc      = 32'h0000_1000 + 32'(vectors.size() * 4);
    v.msg.seq_num = seq_ctr;
    v.msg.op1     = op1;
    v.msg.op2     = op2;
    v.msg.waddr   = waddr;
    v.msg.uop     = uop;
    v.wdata       = wdata;
    v.wen         = wen;
    vectors.push_back(v);
    seq_ctr = seq_ctr + 1'b1;
  endtask

  task automatic build_table();
    seq_ctr = '0;
    // Add and sub with signed overflow and carry out
    add_vec(exec_pkg::UOP_ADD, 32'h0000_0005, 32'h0000_0007, 5'd1, 32'h0000_000C, 1'b1);
    add_vec(exec_pkg::UOP_ADD, 32'h7FFF_FFFF, 32'h0000_0001, 5'd2, 32'h8000_0000, 1'b1);
    add_vec(exec_pkg::UOP_ADD, 32'hFFFF_FFFF, 32'h0000_0002, 5'd3, 32'h0000_0001, 1'b1);
    add_vec(exec_pkg::UOP_SUB, 32'h0000_0003, 32'h0000_0005, 5'd4, 32'hFFFF_FFFE, 1'b1);
    add_vec(exec_pkg::UOP_SUB, 32'h8000_0000, 32'h0000_0001, 5'd5, 32'h7FFF_FFFF, 1'b1);
    // Bitwise logic
    add_vec(exec_pkg::UOP_AND, 32'hF0F0_1234, 32'h0FF0_FF00, 5'd6, 32'h00F0_1200, 1'b1);
    add_vec(exec_pkg::UOP_OR,  32'hF000_000F, 32'h0F00_00F0, 5'd7, 32'hFF00_00FF, 1'b1);
    add_vec(exec_pkg::UOP_XOR, 32'hAAAA_5555, 32'hFFFF_0000, 5'd8, 32'h5555_5555, 1'b1);
    // Shifts with some op2 amounts above 31
    add_vec(exec_pkg::UOP_SLL, 32'h0000_0001, 32'h0000_001F, 5'd9, 32'h8000_0000, 1'b1);
    add_vec(exec_pkg::UOP_SLL, 32'h0000_0003, 32'h0000_0024, 5'd10, 32'h0000_0030, 1'b1);
    add_vec(exec_pkg::UOP_SRL, 32'h8000_0000, 32'h0000_0004, 5'd11, 32'h0800_0000, 1'b1);
    add_vec(exec_pkg::UOP_SRL, 32'hF000_0000, 32'hFFFF_FFE1, 5'd12, 32'h7800_0000, 1'b1);
    add_vec(exec_pkg::UOP_SRA, 32'h8000_0000, 32'h0000_0004, 5'd13, 32'hF800_0000, 1'b1);
    add_vec(exec_pkg::UOP_SRA, 32'hFFFF_FF00, 32'h0000_0028, 5'd14, 32'hFFFF_FFFF, 1'b1);
    add_vec(exec_pkg::UOP_SRA, 32'h7000_0000, 32'h0000_001C, 5'd15, 32'h0000_0007, 1'b1);
    // Signed against unsigned compare on mixed signs
    add_vec(exec_pkg::UOP_SLT,  32'hFFFF_FFFF, 32'h0000_0001, 5'd16, 32'h0000_0001, 1'b1);
    add_vec(exec_pkg::UOP_SLTU, 32'hFFFF_FFFF, 32'h0000_0001, 5'd17, 32'h0000_0000, 1'b1);
    add_vec(exec_pkg::UOP_SLT,  32'h0000_0001, 32'h8000_0000, 5'd18, 32'h0000_0000, 1'b1);
    add_vec(exec_pkg::UOP_SLTU, 32'h0000_0001, 32'h8000_0000, 5'd19, 32'h0000_0001, 1'b1);
    add_vec(exec_pkg::UOP_SLT,  32'h0000_0005, 32'h0000_0005, 5'd20, 32'h0000_0000, 1'b1);
    // LUI passes op2 through
    add_vec(exec_pkg::UOP_LUI, 32'hDEAD_BEEF, 32'h1234_5000, 5'd21, 32'h1234_5000, 1'b1);
    // x0 targets drop wen
    add_vec(exec_pkg::UOP_ADD, 32'h0000_0010, 32'h0000_0020, 5'd0, 32'h0000_0030, 1'b0);
    add_vec(exec_pkg::UOP_LUI, 32'h0000_0000, 32'hFFFF_F000, 5'd0, 32'hFFFF_F000, 1'b0);
    add_vec(exec_pkg::UOP_XOR, 32'h1234_5678, 32'h1234_5678, 5'd31, 32'h0000_0000, 1'b1);
  endtask

  //--------------------------------------------------------------------
  // Scoreboard
  //--------------------------------------------------------------------

  task automatic check_field(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got == exp) else begin
      $display("CHECK FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, got);
      check_errors++;
    end
  endtask

  task automatic record_result(input exec_pkg::x_w_msg_t got);
    exec_pkg::x_w_msg_t exp;
    if (!pending[got.seq_num]) begin
      $display("Result for seq_num %0d arrived at %0t with no request outstanding",
               got.seq_num, $time);
      tag_errors++;
    end else begin
      exp = expected[got.seq_num];
      check_field("w_msg.pc", exp.pc, got.pc);
      check_field("w_msg.waddr", 32'(exp.waddr), 32'(got.waddr));
      check_field("w_msg.wdata", exp.wdata, got.wdata);
      check_field("w_msg.wen", 32'(exp.wen), 32'(got.wen));
      pending[got.seq_num] = 1'b0;
      pending_count--;
      seen_count++;
    end
  endtask

  // W transfers sampled at the falling edge
  always @(negedge clk) begin
    if (!rst && w_val && w_rdy) begin
      record_result(w_msg);
    end
  end

  //--------------------------------------------------------------------
  // Driver
  //--------------------------------------------------------------------

  task automatic send_vec(input vec_t v);
    exec_pkg::x_w_msg_t exp;
    int   waited;
    logic accepted;
    exp.pc      = v.msg.pc;
    exp.seq_num = v.msg.seq_num;
    exp.waddr   = v.msg.waddr;
    exp.wdata   = v.wdata;
    exp.wen     = v.wen;
    expected[v.msg.seq_num] = exp;
    if (!pending[v.msg.seq_num]) begin
      pending[v.msg.seq_num] = 1'b1;
      pending_count++;
    end
    d_msg <= v.msg;
    d_val <= 1'b1;
    waited   = 0;
    accepted = 1'b0;
    while (!accepted && waited < rdy_timeout) begin
      @(negedge clk);
      accepted = d_rdy;
      @(posedge clk);
      waited++;
    end
    if (accepted) begin
      sent_count++;
    end else begin
      $display("Timed out waiting for d_rdy with seq_num %0d", v.msg.seq_num);
      timeout_errors++;
    end
  endtask

  task automatic send_all();
    for (int i = 0; i < vectors.size(); i++) begin
      send_vec(vectors[i]);
    end
    d_val <= 1'b0;
  endtask

  task automatic drain_results();
    int waited;
    waited = 0;
    while (pending_count != 0 && waited < drain_timeout) begin
      @(posedge clk);
      waited++;
    end
    if (pending_count != 0) begin
      $display("%0d results never arrived on the W port", pending_count);
      missing_errors += pending_count;
    end
    // Anything arriving in the quiet tail is a duplicate
    for (int c = 0; c < tail_cycles; c++) begin
      @(posedge clk);
    end
  endtask

  //--------------------------------------------------------------------
  // Main sequence
  //--------------------------------------------------------------------

  initial begin
    void'($urandom(32'h5fbf_1427));
    rst     = 1'b1;
    d_val   = 1'b0;
    d_msg   = '0;
    bp_mode = 1'b0;
    for (int t = 0; t < tag_count; t++) begin
      pending[t] = 1'b0;
    end
    build_table();

    repeat (10) @(posedge clk);
    rst <= 1'b0;

    // Idle state straight out of reset
    @(negedge clk);
    check_field("w_val", 32'd0, 32'(w_val));
    check_field("d_rdy", 32'd1, 32'(d_rdy));

    @(posedge clk);
    $display("Phase 1: back-to-back ops, w_rdy held high");
    send_all();
    drain_results();

    $display("Phase 2: random back-pressure on w_rdy");
    bp_mode <= 1'b1;
    send_all();
    drain_results();

    check_field("w result count", 32'(sent_count), 32'(seen_count));
    $display("Errors: check=%0d tag=%0d timeout=%0d missing=%0d",
             check_errors, tag_errors, timeout_errors, missing_errors);
    if (check_errors + tag_errors + timeout_errors + missing_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
